// ==== bench/clockDisplayTb.sv ====
module clockDisplayTb import vgaPkg::*; import clockFacePkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int     ClkPeriod      = 4;
	localparam int     CyclesPerFrame = 420000;    // 800 x 525 pixels
	localparam int     FramesUsed     = 13;        // Sum over all tests, locking included
	localparam int     WatchdogNs     = (FramesUsed + 2) * CyclesPerFrame * ClkPeriod;
	localparam int     ResetDelay     = 267400;    // Line 490 to x 200 of line 299 next frame
	localparam int     ResetCycles    = 153000;    // Across the hSync pulses into line 490
	localparam color_t PanelColor     = 12'h345;
	localparam color_t DigitColor     = 12'hFF0;
	localparam color_t AlarmColor     = 12'hF00;
	localparam int     ColStart [6]   = '{34, 54, 79, 99, 124, 144};
	localparam int     RowStart [3]   = '{26, 85, 145};   // Date, time, timer

	logic        CLK;
	logic        rst;
	rtcTime_t    rtcTime;
	logic        alarm;
	color_t      color;
	logic        hSync;
	logic        vSync;
	regionCode_t regionCode;

	int          seed         = 32'hf78b_e75d;
	int          colorErrors  = 0;
	int          regionErrors = 0;
	int          syncErrors   = 0;
	int          otherErrors  = 0;
	int          tx           = 0;     // Model position of the pixel now on the outputs
	int          ty           = 0;
	int          resetChecks  = 0;
	logic        rstLate      = 1'b1;  // rst as the DUT sampled it at the last edge
	logic        prevH        = 1'b1;
	logic        prevV        = 1'b1;
	logic        lockedH      = 1'b0;
	logic        lockedV      = 1'b0;
	logic        checking     = 1'b0;  // Set from the first full frame after lock
	logic        seen [32];            // Region codes shown since the last input change
	regionCode_t expCode;
	color_t      expColor;
	event        vblank;               // Outputs reached line 490

	initial begin
		CLK = 1'b0;
		forever #(ClkPeriod / 2) CLK = ~CLK;
	end

	clockDisplay clockDisplay_i (
		.CLK(CLK),
		.rst(rst),
		.rtcTime(rtcTime),
		.alarm(alarm),
		.color(color),
		.hSync(hSync),
		.vSync(vSync),
		.regionCode(regionCode)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic bit between(int v, int lo, int hi);
		return (v >= lo) && (v <= hi);   // Inclusive bounds
	endfunction

	// Usual seven segment shapes, 3 pixels thick
	function automatic bit segmentHit(logic [3:0] d, int lx, int ly);
		if (d > 4'd9) begin
			return 1'b0;   // Not BCD, all dark
		end
		return (!(d inside {1, 4}) && between(ly, 0, 2) && between(lx, 3, 16))        // a
			|| (!(d inside {5, 6}) && between(lx, 17, 19) && between(ly, 3, 13))     // b
			|| ((d != 2) && between(lx, 17, 19) && between(ly, 16, 26))              // c
			|| (!(d inside {1, 4, 7}) && between(ly, 27, 29) && between(lx, 3, 16))  // d
			|| ((d inside {0, 2, 6, 8}) && between(lx, 0, 2) && between(ly, 16, 26))
			|| (!(d inside {1, 2, 3, 7}) && between(lx, 0, 2) && between(ly, 3, 13))
			|| (!(d inside {0, 1, 7}) && between(ly, 13, 15) && between(lx, 3, 16));  // g
	endfunction

	task automatic expectPixel(input int x, input int y, output regionCode_t code,
			output color_t col);
		int          px;
		int          py;
		logic [71:0] fields;
		logic [7:0]  field;
		px     = x - 100;      // Panel corner at (100,100)
		py     = y - 100;
		fields = rtcTime;
		code   = 5'd0;
		col    = 12'h000;
		if (x < 640 && y < 480 && between(px, 0, 199) && between(py, 0, 199)) begin
			code = 5'd1;
			col  = PanelColor;
			if (alarm && px >= 175 && py >= 175) begin
				code = 5'd20;   // Icon in the lower right
				col  = AlarmColor;
			end
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 6; c++) begin
					if (between(px - ColStart[c], 0, 19) && between(py - RowStart[r], 0, 29)) begin
						code  = regionCode_t'(2 + r * 6 + c);
						field = fields[71 - 8 * (r * 3 + c / 2) -: 8];   // Day is the top byte
						col   = segmentHit((c % 2 == 0) ? field[7:4] : field[3:0],
							px - ColStart[c], py - RowStart[r]) ? DigitColor : PanelColor;
					end
				end
			end
		end
	endtask

	// Mode 0 valid BCD, mode 1 bad units digits, mode 2 both digits bad
	function automatic rtcTime_t randomTime(int mode);
		logic [71:0] fields;
		logic [3:0]  hi;
		logic [3:0]  lo;
		for (int i = 0; i < 9; i++) begin
			hi = 4'($unsigned($random(seed)) % 10);
			lo = 4'($unsigned($random(seed)) % 10);
			if (mode > 0) begin
				lo = 4'(10 + $unsigned($random(seed)) % 6);
			end
			if (mode > 1) begin
				hi = 4'(10 + $unsigned($random(seed)) % 6);
			end
			fields[8 * i +: 8] = {hi, lo};
		end
		return rtcTime_t'(fields);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic checkColor(color_t got, color_t exp);
		if (got !== exp) begin
			colorErrors++;
			$display("mismatch color got %h expected %h at x=%0d y=%0d", got, exp, tx, ty);
		end
	endtask

	task automatic checkRegion(regionCode_t got, regionCode_t exp);
		if (got !== exp) begin
			regionErrors++;
			$display("mismatch regionCode got %h expected %h at x=%0d y=%0d", got, exp, tx, ty);
		end
	endtask

	task automatic checkSync(string name, logic got, logic exp);
		if (got !== exp) begin
			syncErrors++;
			$display("mismatch %s got %h expected %h at x=%0d y=%0d", name, got, exp, tx, ty);
		end
	endtask

	task automatic checkRegionsSeen(int first, int last, bit want);
		for (int c = first; c <= last; c++) begin
			if (seen[c] !== want) begin
				otherErrors++;
				$display("region code %0d was %s in the last frame", c,
					want ? "never shown" : "shown");
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output monitor, X and Y recovered from the syncs
	//////////////////////////////////////////////////////////////////////

	always @(posedge CLK) begin
		rstLate <= rst;
	end

	always @(negedge CLK) begin
		if (rstLate) begin
			checkSync("hSync", hSync, 1'b1);   // Everything idle during reset
			checkSync("vSync", vSync, 1'b1);
			checkColor(color, 12'h000);
			checkRegion(regionCode, 5'd0);
			resetChecks++;
			lockedH  = 1'b0;
			lockedV  = 1'b0;
			checking = 1'b0;
		end else begin
			tx++;
			if (tx == 800) begin
				tx = 0;
				ty = (ty == 524) ? 0 : ty + 1;
			end
			if (!lockedH && prevH && !hSync) begin
				tx      = 656;   // First low hSync cycle
				lockedH = 1'b1;
			end
			if (lockedH && !lockedV && prevV && !vSync) begin
				ty      = 490;
				lockedV = 1'b1;
			end
			if (lockedV && tx == 0 && ty == 0) begin
				checking = 1'b1;
			end
			if (checking) begin
				expectPixel(tx, ty, expCode, expColor);
				checkSync("hSync", hSync, !between(tx, 656, 751));
				checkSync("vSync", vSync, !between(ty, 490, 491));
				checkColor(color, expColor);
				checkRegion(regionCode, expCode);
				seen[regionCode] = 1'b1;
				if (tx == 0 && ty == 490) begin
					-> vblank;
				end
			end
		end
		prevH = hSync;
		prevV = vSync;
	end

	//////////////////////////////////////////////////////////////////////
	// Directed tests, each starts right after a vblank event
	//////////////////////////////////////////////////////////////////////

	task automatic applyInputs(rtcTime_t t, logic a);
		@(posedge CLK);
		rtcTime <= t;        // Still inside vertical blanking
		alarm   <= a;
		foreach (seen[i]) begin
			seen[i] = 1'b0;
		end
	endtask

	task automatic testSyncTiming();
		wait (checking);
		@(vblank);
		@(vblank);
	endtask

	task automatic testDigits();
		for (int i = 0; i < 3; i++) begin
			applyInputs(randomTime(0), 1'b0);
			@(vblank);
			checkRegionsSeen(2, 19, 1'b1);
		end
	endtask

	task automatic testInvalidNibbles();
		applyInputs(randomTime(1), 1'b0);
		@(vblank);
		applyInputs(randomTime(2), 1'b0);
		@(vblank);
		checkRegionsSeen(2, 19, 1'b1);
	endtask

	task automatic testAlarm();
		applyInputs(randomTime(0), 1'b1);
		@(vblank);
		checkRegionsSeen(20, 20, 1'b1);
		applyInputs(rtcTime, 1'b0);
		@(vblank);
		checkRegionsSeen(20, 20, 1'b0);
	endtask

	task automatic testReset();
		resetChecks = 0;
		repeat (ResetDelay) @(posedge CLK);   // Bottom line of the panel
		rst <= 1'b1;
		repeat (ResetCycles) @(posedge CLK);
		rst <= 1'b0;
		wait (checking);
		@(vblank);
		if (resetChecks != ResetCycles) begin
			otherErrors++;
			$display("reset was seen on the outputs for %0d cycles instead of %0d",
				resetChecks, ResetCycles);
		end
	endtask

	initial begin
		rst     = 1'b1;
		alarm   = 1'b0;
		rtcTime = '0;
		repeat (3) @(posedge CLK);
		rst <= 1'b0;
		testSyncTiming();
		testDigits();
		testInvalidNibbles();
		testAlarm();
		testReset();
		$display("errors: color %0d, region %0d, sync %0d, other %0d",
			colorErrors, regionErrors, syncErrors, otherErrors);
		if (colorErrors + regionErrors + syncErrors + otherErrors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WatchdogNs);
		$display("timeout, the tests did not finish within %0d ns", WatchdogNs);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== clockDisplay.f ====
rtl/vgaPkg.sv
rtl/clockFacePkg.sv
rtl/vgaSync.sv
rtl/regionDecoder.sv
rtl/glyphRenderer.sv
rtl/clockDisplay.sv
bench/clockDisplayTb.sv

// ==== rtl/clockDisplay.sv ====
module clockDisplay import vgaPkg::*; import clockFacePkg::*; (
	input  logic        CLK,
	input  logic        rst,
	input  rtcTime_t    rtcTime,
	input  logic        alarm,
	output color_t      color,
	output logic        hSync,
	output logic        vSync,
	output regionCode_t regionCode
);

	//////////////////////////////////////////////////////////////////////
	// Layout and timing
	//////////////////////////////////////////////////////////////////////

	localparam int     PanelX     = 100;      // Panel corner on screen
	localparam int     PanelY     = 100;
	localparam color_t PanelColor = 12'h345;
	localparam color_t DigitColor = 12'hFF0;
	localparam color_t AlarmColor = 12'hF00;

	pixelBeat_t beat;  // Stage 1 to 2
	glyphReq_t  req;   // Stage 2 to 3

	// 640x480 at 60 Hz
	vgaSync #(
		.HActive(640), .HFront(16), .HPulse(96), .HBack(48),
		.VActive(480), .VFront(10), .VPulse(2), .VBack(33)
	) vgaSync_i (
		.CLK(CLK),
		.rst(rst),
		.beat(beat)
	);

	regionDecoder #(.PanelX(PanelX), .PanelY(PanelY)) regionDecoder_i (
		.CLK(CLK),
		.rst(rst),
		.beat(beat),
		.rtcTime(rtcTime),
		.alarm(alarm),
		.req(req)
	);

	glyphRenderer #(
		.PanelColor(PanelColor),
		.DigitColor(DigitColor),
		.AlarmColor(AlarmColor)
	) glyphRenderer_i (
		.CLK(CLK),
		.rst(rst),
		.req(req),
		.color(color),
		.hSync(hSync),
		.vSync(vSync),
		.regionCode(regionCode)
	);

endmodule

// ==== rtl/clockFacePkg.sv ====
package clockFacePkg;

	//////////////////////////////////////////////////////////////////////
	// Clock fields from the RTC
	//////////////////////////////////////////////////////////////////////

	typedef logic [3:0] bcdDigit_t;  // One BCD nibble
	typedef logic [7:0] bcdByte_t;   // Tens in [7:4], units in [3:0]

	// Field order matches the panel rows, date then time then timer
	typedef struct packed {
		bcdByte_t day;
		bcdByte_t month;
		bcdByte_t year;
		bcdByte_t hour;
		bcdByte_t minute;
		bcdByte_t second;
		bcdByte_t timerHour;
		bcdByte_t timerMinute;
		bcdByte_t timerSecond;
	} rtcTime_t;

	//////////////////////////////////////////////////////////////////////
	// Panel layout, offsets from the panel corner
	//////////////////////////////////////////////////////////////////////

	localparam int PanelSize  = 200;
	localparam int AlarmStart = 175;  // Icon is 25x25 in the lower right
	localparam int CellWidth  = 20;
	localparam int CellHeight = 30;
	localparam int CellCols   = 6;
	localparam int CellRows   = 3;
	localparam int CellColumn [CellCols] = '{34, 54, 79, 99, 124, 144};
	localparam int CellRow    [CellRows] = '{26, 85, 145};  // Date, time, timer

	//////////////////////////////////////////////////////////////////////
	// Region codes and the decoder to renderer request
	//////////////////////////////////////////////////////////////////////

	typedef logic [4:0] regionCode_t;
	typedef logic [4:0] cellPos_t;    // Cell local X 0..19 and Y 0..29
	typedef logic [6:0] segments_t;   // Segment a in bit 6 down to g in bit 0

	localparam regionCode_t RegionOff        = 5'd0;
	localparam regionCode_t RegionPanel      = 5'd1;
	localparam regionCode_t RegionFirstDigit = 5'd2;   // Date row, leftmost cell
	localparam regionCode_t RegionAlarm      = 5'd20;

	typedef enum logic [1:0] {
		KindOff,
		KindPanel,
		KindDigit,
		KindAlarm
	} regionKind_e;

	typedef struct packed {
		regionKind_e kind;
		regionCode_t code;
		bcdDigit_t   nibble;  // Only meaningful for KindDigit
		cellPos_t    cellX;
		cellPos_t    cellY;
		logic        hSync;
		logic        vSync;
		logic        active;
	} glyphReq_t;

	// Seven segment patterns, nibbles above 9 stay dark
	function automatic segments_t segmentTable(input bcdDigit_t nibble);
		case (nibble)
			4'd0: return 7'b1111110;
			4'd1: return 7'b0110000;
			4'd2: return 7'b1101101;
			4'd3: return 7'b1111001;
			4'd4: return 7'b0110011;
			4'd5: return 7'b1011011;
			4'd6: return 7'b1011111;
			4'd7: return 7'b1110000;
			4'd8: return 7'b1111111;
			4'd9: return 7'b1111011;
			default: return 7'b0000000;
		endcase
	endfunction

endpackage

// ==== rtl/glyphRenderer.sv ====
module glyphRenderer import vgaPkg::*; import clockFacePkg::*; #(
	parameter color_t PanelColor = 12'h345,
	parameter color_t DigitColor = 12'hFF0,
	parameter color_t AlarmColor = 12'hF00
) (
	input  logic        CLK,
	input  logic        rst,
	input  glyphReq_t   req,
	output color_t      color,
	output logic        hSync,
	output logic        vSync,
	output regionCode_t regionCode
);

	localparam int SegThick = 3;
	localparam int MidRow   = (CellHeight - SegThick) / 2;  // Top row of segment g
	localparam int BarFirst = SegThick;                     // Horizontal bars span 3..16
	localparam int BarLast  = CellWidth - SegThick - 1;
	localparam int RightCol = CellWidth - SegThick;         // b and c start here
	localparam int BotRow   = CellHeight - SegThick;        // d starts here

	segments_t lit;        // Segments the nibble turns on
	segments_t under;      // Segments under the current pixel
	logic      onSegment;
	logic      inBar;
	logic      inUpper;
	logic      inLower;
	color_t    colorNext;

	//////////////////////////////////////////////////////////////////////
	// Seven segment geometry
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		lit     = segmentTable(req.nibble);
		inBar   = (req.cellX >= BarFirst) && (req.cellX <= BarLast);
		inUpper = (req.cellY >= SegThick) && (req.cellY <= MidRow);
		inLower = (req.cellY >= MidRow + SegThick) && (req.cellY < BotRow);
		under[6] = inBar && (req.cellY < SegThick);                  // a
		under[5] = inUpper && (req.cellX >= RightCol);               // b
		under[4] = inLower && (req.cellX >= RightCol);               // c
		under[3] = inBar && (req.cellY >= BotRow);                   // d
		under[2] = inLower && (req.cellX < SegThick);                // e
		under[1] = inUpper && (req.cellX < SegThick);                // f
		under[0] = inBar && (req.cellY >= MidRow)
			&& (req.cellY < MidRow + SegThick);                      // g
		onSegment = |(lit & under);
	end

	//////////////////////////////////////////////////////////////////////
	// Color pick
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (req.kind)
			KindPanel: colorNext = PanelColor;
			KindAlarm: colorNext = AlarmColor;
			KindDigit: colorNext = onSegment ? DigitColor : PanelColor;
			default:   colorNext = '0;
		endcase
		if (!req.active) begin
			colorNext = '0;   // Blanking is always black
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			color      <= '0;
			hSync      <= 1'b1;
			vSync      <= 1'b1;
			regionCode <= RegionOff;
		end else begin
			color      <= colorNext;
			hSync      <= req.hSync;   // Same pixel as color
			vSync      <= req.vSync;
			regionCode <= req.code;
		end
	end

	// Black outside the visible area
	assert property (@(posedge CLK) disable iff (rst)
		!$past(req.active) |-> (color == '0))
		else $error("glyphRenderer color %h during blanking", color);

endmodule

// ==== rtl/regionDecoder.sv ====
module regionDecoder import vgaPkg::*; import clockFacePkg::*; #(
	parameter int PanelX = 100,
	parameter int PanelY = 100
) (
	input  logic       CLK,
	input  logic       rst,
	input  pixelBeat_t beat,
	input  rtcTime_t   rtcTime,
	input  logic       alarm,
	output glyphReq_t  req
);

	bcdByte_t [8:0]       fieldList;  // Day in element 8 down to timer second in 0
	pixelPos_t            relX;       // Offset from the panel corner
	pixelPos_t            relY;
	logic                 inPanel;
	logic                 inAlarm;
	logic [CellCols-1:0]  colHit;
	logic [CellRows-1:0]  rowHit;
	glyphReq_t            reqNext;

	assign fieldList = rtcTime;
	assign relX      = beat.x - pixelPos_t'(PanelX);  // Wraps when left of the panel
	assign relY      = beat.y - pixelPos_t'(PanelY);

	//////////////////////////////////////////////////////////////////////
	// Panel, icon and cell bounds, all inclusive
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		inPanel = beat.active
			&& (beat.x >= PanelX) && (relX < PanelSize)
			&& (beat.y >= PanelY) && (relY < PanelSize);
		// Icon only shows while the alarm is raised
		inAlarm = inPanel && alarm && (relX >= AlarmStart) && (relY >= AlarmStart);
		for (int c = 0; c < CellCols; c++) begin
			colHit[c] = (relX >= CellColumn[c]) && (relX < CellColumn[c] + CellWidth);
		end
		for (int r = 0; r < CellRows; r++) begin
			rowHit[r] = (relY >= CellRow[r]) && (relY < CellRow[r] + CellHeight);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Region code, nibble and cell local position
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		reqNext        = '0;
		reqNext.kind   = KindOff;
		reqNext.code   = RegionOff;
		reqNext.hSync  = beat.hSync;   // Syncs ride along with the pixel
		reqNext.vSync  = beat.vSync;
		reqNext.active = beat.active;
		if (inAlarm) begin
			reqNext.kind = KindAlarm;  // Wins over the plain panel
			reqNext.code = RegionAlarm;
		end else if (inPanel) begin
			reqNext.kind = KindPanel;
			reqNext.code = RegionPanel;
			for (int r = 0; r < CellRows; r++) begin
				for (int c = 0; c < CellCols; c++) begin
					if (rowHit[r] && colHit[c]) begin
						reqNext.kind  = KindDigit;
						reqNext.code  = regionCode_t'(RegionFirstDigit + r * CellCols + c);
						// Left cell of a pair shows tens
						if (c % 2 == 0) begin
							reqNext.nibble = fieldList[8 - (r * 3 + c / 2)][7:4];
						end else begin
							reqNext.nibble = fieldList[8 - (r * 3 + c / 2)][3:0];
						end
						reqNext.cellX = cellPos_t'(relX - pixelPos_t'(CellColumn[c]));
						reqNext.cellY = cellPos_t'(relY - pixelPos_t'(CellRow[r]));
					end
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			req       <= '0;
			req.kind  <= KindOff;
			req.hSync <= 1'b1;   // Inactive syncs
			req.vSync <= 1'b1;
		end else begin
			req <= reqNext;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	assert property (@(posedge CLK) disable iff (rst)
		req.code <= RegionAlarm)
		else $error("regionDecoder code %0d out of range", req.code);

endmodule

// ==== rtl/vgaPkg.sv ====
package vgaPkg;

	//////////////////////////////////////////////////////////////////////
	// Screen coordinates and colors
	//////////////////////////////////////////////////////////////////////

	// Enough for 800 columns and 525 lines
	typedef logic [9:0] pixelPos_t;

	// 4 bits per channel
	typedef logic [11:0] color_t;

	// Channel layout inside color_t
	localparam int RedMsb   = 11;
	localparam int GreenMsb = 7;
	localparam int BlueMsb  = 3;

	//////////////////////////////////////////////////////////////////////
	// One pixel slot of the raster
	//////////////////////////////////////////////////////////////////////

	// Syncs are active low
	// x and y are the counter values for this slot
	// active is high only inside the visible 640x480 area
	typedef struct packed {
		logic      hSync;  // Low during the horizontal pulse
		logic      vSync;  // Low during the vertical pulse
		logic      active; // Visible area flag
		pixelPos_t x;      // Column, 0 to HTotal-1
		pixelPos_t y;      // Row, 0 to VTotal-1
	} pixelBeat_t;

	// Idle slot as seen during reset
	localparam pixelBeat_t IdleBeat = '{
		hSync:  1'b1,
		vSync:  1'b1,
		active: 1'b0,
		x:      '0,
		y:      '0
	};

endpackage

// ==== rtl/vgaSync.sv ====
module vgaSync import vgaPkg::*; #(
	parameter int HActive = 640,
	parameter int HFront  = 16,
	parameter int HPulse  = 96,
	parameter int HBack   = 48,
	parameter int VActive = 480,
	parameter int VFront  = 10,
	parameter int VPulse  = 2,
	parameter int VBack   = 33
) (
	input  logic       CLK,
	input  logic       rst,
	output pixelBeat_t beat
);

	localparam int HTotal     = HActive + HFront + HPulse + HBack;  // 800
	localparam int VTotal     = VActive + VFront + VPulse + VBack;  // 525
	localparam int HSyncFirst = HActive + HFront;                   // 656
	localparam int HSyncLast  = HSyncFirst + HPulse - 1;            // 751
	localparam int VSyncFirst = VActive + VFront;                   // 490
	localparam int VSyncLast  = VSyncFirst + VPulse - 1;            // 491

	pixelPos_t xNext;
	pixelPos_t yNext;
	logic      lineEnd;
	logic      frameEnd;

	//////////////////////////////////////////////////////////////////////
	// Next counter values
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		lineEnd  = (beat.x == pixelPos_t'(HTotal - 1));
		frameEnd = (beat.y == pixelPos_t'(VTotal - 1));
		xNext    = lineEnd ? '0 : beat.x + 1'b1;
		yNext    = beat.y;            // Y only moves on a line wrap
		if (lineEnd) begin
			yNext = frameEnd ? '0 : beat.y + 1'b1;
		end
	end

	// Syncs and active come from the next values
	// so they line up with the registered counters
	always_ff @(posedge CLK) begin
		if (rst) begin
			beat <= IdleBeat;         // Counters at 0, syncs high
		end else begin
			beat.x      <= xNext;
			beat.y      <= yNext;
			beat.hSync  <= !((xNext >= HSyncFirst) && (xNext <= HSyncLast));
			beat.vSync  <= !((yNext >= VSyncFirst) && (yNext <= VSyncLast));
			beat.active <= (xNext < HActive) && (yNext < VActive);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Counters never leave the frame
	assert property (@(posedge CLK) disable iff (rst)
		(beat.x < HTotal) && (beat.y < VTotal))
		else $error("vgaSync counter out of range x=%0d y=%0d", beat.x, beat.y);

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module clockDisplayTb \
	-f clockDisplay.f -o clockDisplaySim
./obj_dir/clockDisplaySim | tee sim.log
if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
